// File: csr_unit_top.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_op_decode.sv
hdl/csr_regfile.sv
hdl/csr_irq_arbiter.sv
hdl/csr_unit_top.sv
testbench/csr_unit_tb.sv

// File: hdl/csr_irq_arbiter.sv
`timescale 1ns/100ps

`include "csr_macros.svh"

module csr_irq_arbiter (
  input  logic                    clk_i,
  input  logic                    rstn_i,

  input  logic [`CSR_IRQ_NUM-1:0] mip_i,          // pending
  input  logic [`CSR_IRQ_NUM-1:0] mie_i,          // enabled
  input  logic                    mstatus_mie_i,  // global enable
  input  csr_pkg::csr_data_t      mtvec_base_i,

  output logic                    irq_req_o,      // level
  output csr_pkg::csr_data_t      irq_cause_o,    // interrupt bit set
  output csr_pkg::csr_data_t      irq_pc_o        // trap target
);

  import csr_pkg::*;

  logic [`CSR_IRQ_NUM-1:0] pend_en;   // pending and enabled
  logic                    req_d;
  csr_data_t               cause_d;

  //////////////////////////////
  // gating and priority
  //////////////////////////////
  always_comb begin
    pend_en = mip_i & mie_i & {`CSR_IRQ_NUM{mstatus_mie_i}};
    req_d   = |pend_en;

    // ext > sw > timer
    cause_d = '0;
    if (pend_en[`CSR_IRQ_IDX_ME]) begin
      cause_d = csr_data_t'(`CSR_IRQ_BIT_ME);
    end else if (pend_en[`CSR_IRQ_IDX_MS]) begin
      cause_d = csr_data_t'(`CSR_IRQ_BIT_MS);
    end else if (pend_en[`CSR_IRQ_IDX_MT]) begin
      cause_d = csr_data_t'(`CSR_IRQ_BIT_MT);
    end
    cause_d[`CSR_XLEN-1] = 1'b1;   // interrupt, not exception
  end

  //////////////////////////////
  // output registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      irq_req_o <= 1'b0;
    end else begin
      irq_req_o <= req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_d) begin
      irq_cause_o <= cause_d;   // holds while idle
    end
    irq_pc_o <= mtvec_base_i;   // direct mode, base is the target
  end

endmodule

// File: hdl/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

//////////////////////////////
// widths
//////////////////////////////
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_IRQ_NUM         3       // sw, timer, ext

//////////////////////////////
// machine csr addresses
//////////////////////////////
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// read-only values
`define CSR_DEF_MVENDORID   32'h0000_0000   // non-commercial
`define CSR_DEF_MARCHID     32'h0000_0000
`define CSR_DEF_MIMPID      32'h0000_0001
`define CSR_DEF_MHARTID     32'h0000_0000   // single hart
`define CSR_DEF_MISA        32'h4000_0100   // mxl=1, I only

`define CSR_TRAP_VEC_BASE   32'h0000_0100   // mtvec after reset, direct mode

// mstatus fields
`define CSR_MSTATUS_BIT_MIE   3
`define CSR_MSTATUS_BIT_MPIE  7

// mip/mie bit positions, also the interrupt cause codes
`define CSR_IRQ_BIT_MS      3
`define CSR_IRQ_BIT_MT      7
`define CSR_IRQ_BIT_ME      11

// index into the compact 3-bit pending/enable vectors
`define CSR_IRQ_IDX_MS      0
`define CSR_IRQ_IDX_MT      1
`define CSR_IRQ_IDX_ME      2

`endif

// File: hdl/csr_op_decode.sv
`timescale 1ns/100ps

`include "csr_macros.svh"

module csr_op_decode (
  input  logic                   clk_i,
  input  logic                   rstn_i,

  // csr instruction from the core
  input  logic                   csr_valid_i,     // one-cycle strobe
  input  logic [2:0]             funct3_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_data_t     rs1_data_i,
  input  logic [4:0]             uimm_i,          // zimm field
  input  logic                   rs1_is_zero_i,   // rs1 / uimm field is zero

  // registered request to the register file
  output logic                   dec_valid_o,
  output csr_pkg::csr_op_e       dec_op_o,
  output logic [`CSR_ADDR_W-1:0] dec_addr_o,
  output csr_pkg::csr_data_t     dec_operand_o,
  output logic                   dec_wr_suppress_o
);

  import csr_pkg::*;

  csr_op_e   op_d;
  csr_data_t operand_d;
  logic      suppress_d;

  //////////////////////////////
  // funct3 decode
  //////////////////////////////
  always_comb begin
    // funct3[1:0] picks the op, funct3[2] picks the immediate form
    case (funct3_i[1:0])
      2'b01:   op_d = CSR_RW;
      2'b10:   op_d = CSR_RS;
      2'b11:   op_d = CSR_RC;
      default: op_d = CSR_NONE;   // funct3 0 and 4
    endcase

    operand_d = funct3_i[2] ? csr_data_t'(uimm_i) : rs1_data_i;   // uimm zero-extended

    // set/clear with x0 or zero uimm is a pure read
    suppress_d = rs1_is_zero_i && ((op_d == CSR_RS) || (op_d == CSR_RC));
  end

  //////////////////////////////
  // request register
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= csr_valid_i;
    end
  end

  // payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      dec_op_o          <= op_d;
      dec_addr_o        <= csr_addr_i;
      dec_operand_o     <= operand_d;
      dec_wr_suppress_o <= suppress_d;
    end
  end

endmodule

// File: hdl/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

  //////////////////////////////
  // csr operation
  //////////////////////////////
  // register and immediate forms decode to the same op,
  // only the operand source differs
  typedef enum logic [1:0] {
    CSR_NONE = 2'b00,   // not a csr op, answered as illegal
    CSR_RW   = 2'b01,   // swap
    CSR_RS   = 2'b10,   // set bits
    CSR_RC   = 2'b11    // clear bits
  } csr_op_e;

  //////////////////////////////
  // data word
  //////////////////////////////
  typedef logic [`CSR_XLEN-1:0] csr_data_t;   // register value, operand, pc

endpackage

// File: hdl/csr_regfile.sv
`timescale 1ns/100ps

`include "csr_macros.svh"

module csr_regfile (
  input  logic                    clk_i,
  input  logic                    rstn_i,

  // decoded request
  input  logic                    dec_valid_i,
  input  csr_pkg::csr_op_e        dec_op_i,
  input  logic [`CSR_ADDR_W-1:0]  dec_addr_i,
  input  csr_pkg::csr_data_t      dec_operand_i,
  input  logic                    dec_wr_suppress_i,

  // trap control from the core
  input  logic                    trap_i,        // pulse
  input  csr_pkg::csr_data_t      trap_pc_i,
  input  logic                    mret_i,        // pulse

  // interrupt lines
  input  logic                    sw_irq_i,
  input  logic                    timer_irq_i,
  input  logic                    ext_irq_i,
  input  csr_pkg::csr_data_t      irq_cause_i,   // from arbiter, taken on trap

  // response to the core
  output csr_pkg::csr_data_t      rdata_o,
  output logic                    rdata_valid_o,
  output logic                    illegal_o,

  // state towards the arbiter
  output logic [`CSR_IRQ_NUM-1:0] mip_o,
  output logic [`CSR_IRQ_NUM-1:0] mie_o,
  output logic                    mstatus_mie_o,
  output csr_pkg::csr_data_t      mtvec_base_o
);

  import csr_pkg::*;

  //////////////////////////////
  // state
  //////////////////////////////
  logic                    mstatus_mie_q;    // global interrupt enable
  logic                    mstatus_mpie_q;   // mie before trap
  csr_data_t               mtvec_q;          // mode bits always 0
  logic [`CSR_IRQ_NUM-1:0] mip_q;            // sampled lines
  logic [`CSR_IRQ_NUM-1:0] mie_q;
  csr_data_t               mscratch_q;
  csr_data_t               mepc_q;
  csr_data_t               mcause_q;

  // full-width views of the sparse registers
  csr_data_t mstatus_val;
  csr_data_t mip_val;
  csr_data_t mie_val;

  csr_data_t old_val;      // value before the access
  csr_data_t new_val;      // value after read-modify-write
  logic      addr_known;
  logic      read_only;
  logic      wr_req;       // op wants to write
  logic      illegal;
  logic      do_write;

  always_comb begin
    mstatus_val = '0;
    mstatus_val[`CSR_MSTATUS_BIT_MIE]  = mstatus_mie_q;
    mstatus_val[`CSR_MSTATUS_BIT_MPIE] = mstatus_mpie_q;

    mip_val = '0;
    mip_val[`CSR_IRQ_BIT_MS] = mip_q[`CSR_IRQ_IDX_MS];
    mip_val[`CSR_IRQ_BIT_MT] = mip_q[`CSR_IRQ_IDX_MT];
    mip_val[`CSR_IRQ_BIT_ME] = mip_q[`CSR_IRQ_IDX_ME];

    mie_val = '0;
    mie_val[`CSR_IRQ_BIT_MS] = mie_q[`CSR_IRQ_IDX_MS];
    mie_val[`CSR_IRQ_BIT_MT] = mie_q[`CSR_IRQ_IDX_MT];
    mie_val[`CSR_IRQ_BIT_ME] = mie_q[`CSR_IRQ_IDX_ME];
  end

  //////////////////////////////
  // address decode, old value
  //////////////////////////////
  always_comb begin
    old_val    = '0;
    addr_known = 1'b1;
    read_only  = 1'b0;
    case (dec_addr_i)
      `CSR_ADDR_MVENDORID: begin
        old_val   = `CSR_DEF_MVENDORID;
        read_only = 1'b1;
      end
      `CSR_ADDR_MARCHID: begin
        old_val   = `CSR_DEF_MARCHID;
        read_only = 1'b1;
      end
      `CSR_ADDR_MIMPID: begin
        old_val   = `CSR_DEF_MIMPID;
        read_only = 1'b1;
      end
      `CSR_ADDR_MHARTID: begin
        old_val   = `CSR_DEF_MHARTID;
        read_only = 1'b1;
      end
      `CSR_ADDR_MISA: begin
        old_val   = `CSR_DEF_MISA;
        read_only = 1'b1;
      end
      `CSR_ADDR_MIP: begin
        old_val   = mip_val;   // lines, not software writable
        read_only = 1'b1;
      end
      `CSR_ADDR_MSTATUS:  old_val = mstatus_val;
      `CSR_ADDR_MIE:      old_val = mie_val;
      `CSR_ADDR_MTVEC:    old_val = mtvec_q;
      `CSR_ADDR_MSCRATCH: old_val = mscratch_q;
      `CSR_ADDR_MEPC:     old_val = mepc_q;
      `CSR_ADDR_MCAUSE:   old_val = mcause_q;
      default:            addr_known = 1'b0;
    endcase
  end

  // read-modify-write and legality
  always_comb begin
    case (dec_op_i)
      CSR_RW:  new_val = dec_operand_i;
      CSR_RS:  new_val = old_val | dec_operand_i;
      CSR_RC:  new_val = old_val & ~dec_operand_i;
      default: new_val = old_val;
    endcase

    wr_req   = (dec_op_i != CSR_NONE) && !dec_wr_suppress_i;
    illegal  = !addr_known || (dec_op_i == CSR_NONE) || (wr_req && read_only);
    do_write = dec_valid_i && wr_req && !illegal;
  end

  //////////////////////////////
  // control state
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mtvec_q        <= `CSR_TRAP_VEC_BASE;
      mie_q          <= '0;
      mip_q          <= '0;
      rdata_valid_o  <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      // trap and mret win over a software write
      if (trap_i) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
      end else if (mret_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end else if (do_write && (dec_addr_i == `CSR_ADDR_MSTATUS)) begin
        mstatus_mie_q  <= new_val[`CSR_MSTATUS_BIT_MIE];
        mstatus_mpie_q <= new_val[`CSR_MSTATUS_BIT_MPIE];
      end

      if (do_write && (dec_addr_i == `CSR_ADDR_MTVEC)) begin
        mtvec_q <= {new_val[`CSR_XLEN-1:2], 2'b00};   // direct mode only
      end

      if (do_write && (dec_addr_i == `CSR_ADDR_MIE)) begin
        mie_q[`CSR_IRQ_IDX_MS] <= new_val[`CSR_IRQ_BIT_MS];
        mie_q[`CSR_IRQ_IDX_MT] <= new_val[`CSR_IRQ_BIT_MT];
        mie_q[`CSR_IRQ_IDX_ME] <= new_val[`CSR_IRQ_BIT_ME];
      end

      mip_q[`CSR_IRQ_IDX_MS] <= sw_irq_i;      // one cycle of sampling
      mip_q[`CSR_IRQ_IDX_MT] <= timer_irq_i;
      mip_q[`CSR_IRQ_IDX_ME] <= ext_irq_i;

      rdata_valid_o <= dec_valid_i;
      illegal_o     <= dec_valid_i && illegal;
    end
  end

  //////////////////////////////
  // data registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (do_write && (dec_addr_i == `CSR_ADDR_MSCRATCH)) begin
      mscratch_q <= new_val;
    end

    if (trap_i) begin
      mepc_q <= {trap_pc_i[`CSR_XLEN-1:2], 2'b00};   // word aligned
    end else if (do_write && (dec_addr_i == `CSR_ADDR_MEPC)) begin
      mepc_q <= {new_val[`CSR_XLEN-1:2], 2'b00};
    end

    if (trap_i) begin
      mcause_q <= irq_cause_i;
    end else if (do_write && (dec_addr_i == `CSR_ADDR_MCAUSE)) begin
      mcause_q <= new_val;
    end

    if (dec_valid_i) begin
      rdata_o <= illegal ? '0 : old_val;   // illegal reads zero
    end
  end

  // levels for the arbiter
  assign mip_o         = mip_q;
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mtvec_base_o  = mtvec_q;

endmodule

// File: hdl/csr_unit_top.sv
`timescale 1ns/100ps

`include "csr_macros.svh"

module csr_unit_top (
  input  logic                   clk_i,
  input  logic                   rstn_i,

  // csr instruction
  input  logic                   csr_valid_i,
  input  logic [2:0]             funct3_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_data_t     rs1_data_i,
  input  logic [4:0]             uimm_i,
  input  logic                   rs1_is_zero_i,

  // trap control
  input  logic                   trap_i,
  input  csr_pkg::csr_data_t     trap_pc_i,
  input  logic                   mret_i,

  // interrupt lines
  input  logic                   sw_irq_i,
  input  logic                   timer_irq_i,
  input  logic                   ext_irq_i,

  // csr response, 2 cycles after csr_valid_i
  output csr_pkg::csr_data_t     rdata_o,
  output logic                   rdata_valid_o,
  output logic                   illegal_o,

  // interrupt request
  output logic                   irq_req_o,
  output csr_pkg::csr_data_t     irq_cause_o,
  output csr_pkg::csr_data_t     irq_pc_o
);

  import csr_pkg::*;

  // stage 1 -> stage 2
  logic                    dec_valid;
  csr_op_e                 dec_op;
  logic [`CSR_ADDR_W-1:0]  dec_addr;
  csr_data_t               dec_operand;
  logic                    dec_wr_suppress;

  // stage 2 <-> stage 3
  logic [`CSR_IRQ_NUM-1:0] mip_q;
  logic [`CSR_IRQ_NUM-1:0] mie_q;
  logic                    mstatus_mie_q;
  csr_data_t               mtvec_base_q;

  //////////////////////////////
  // stage 1, decode
  //////////////////////////////
  csr_op_decode u_decode (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .csr_valid_i       (csr_valid_i),
    .funct3_i          (funct3_i),
    .csr_addr_i        (csr_addr_i),
    .rs1_data_i        (rs1_data_i),
    .uimm_i            (uimm_i),
    .rs1_is_zero_i     (rs1_is_zero_i),
    .dec_valid_o       (dec_valid),
    .dec_op_o          (dec_op),
    .dec_addr_o        (dec_addr),
    .dec_operand_o     (dec_operand),
    .dec_wr_suppress_o (dec_wr_suppress)
  );

  //////////////////////////////
  // stage 2, register file
  //////////////////////////////
  csr_regfile u_regfile (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .dec_valid_i       (dec_valid),
    .dec_op_i          (dec_op),
    .dec_addr_i        (dec_addr),
    .dec_operand_i     (dec_operand),
    .dec_wr_suppress_i (dec_wr_suppress),
    .trap_i            (trap_i),
    .trap_pc_i         (trap_pc_i),
    .mret_i            (mret_i),
    .sw_irq_i          (sw_irq_i),
    .timer_irq_i       (timer_irq_i),
    .ext_irq_i         (ext_irq_i),
    .irq_cause_i       (irq_cause_o),   // cause of the pending request
    .rdata_o           (rdata_o),
    .rdata_valid_o     (rdata_valid_o),
    .illegal_o         (illegal_o),
    .mip_o             (mip_q),
    .mie_o             (mie_q),
    .mstatus_mie_o     (mstatus_mie_q),
    .mtvec_base_o      (mtvec_base_q)
  );

  //////////////////////////////
  // stage 3, interrupt arbiter
  //////////////////////////////
  csr_irq_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .mip_i         (mip_q),
    .mie_i         (mie_q),
    .mstatus_mie_i (mstatus_mie_q),
    .mtvec_base_i  (mtvec_base_q),
    .irq_req_o     (irq_req_o),
    .irq_cause_o   (irq_cause_o),
    .irq_pc_o      (irq_pc_o)
  );

endmodule

// File: testbench/csr_unit_tb.sv
`timescale 1ns/100ps

`include "csr_macros.svh"

module csr_unit_tb;

  localparam int TIMEOUT_CYC = 3000;   // all tests take about 600

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic        csr_valid_i;
  logic [2:0]  funct3_i;
  logic [11:0] csr_addr_i;
  logic [31:0] rs1_data_i;
  logic [4:0]  uimm_i;
  logic        rs1_is_zero_i;
  logic        trap_i;
  logic [31:0] trap_pc_i;
  logic        mret_i;
  logic        sw_irq_i;
  logic        timer_irq_i;
  logic        ext_irq_i;
  logic [31:0] rdata_o;
  logic        rdata_valid_o;
  logic        illegal_o;
  logic        irq_req_o;
  logic [31:0] irq_cause_o;
  logic [31:0] irq_pc_o;

  int          cyc = 0;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  logic [31:0] rng_state;

  // outstanding requests, oldest first
  string       exp_name_q[$];
  logic [31:0] exp_data_q[$];
  bit          exp_ill_q[$];
  bit          exp_chk_q[$];   // 0 while old value still unknown
  int          exp_cyc_q[$];   // cycle of the strobe

  // reference copy of the csr state
  logic [31:0] m_mstatus;
  logic [31:0] m_mie;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [2:0]  m_lines;       // {ext, timer, sw}
  bit          scratch_def;   // mscratch has no reset value

  csr_unit_top u_dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .csr_valid_i   (csr_valid_i),
    .funct3_i      (funct3_i),
    .csr_addr_i    (csr_addr_i),
    .rs1_data_i    (rs1_data_i),
    .uimm_i        (uimm_i),
    .rs1_is_zero_i (rs1_is_zero_i),
    .trap_i        (trap_i),
    .trap_pc_i     (trap_pc_i),
    .mret_i        (mret_i),
    .sw_irq_i      (sw_irq_i),
    .timer_irq_i   (timer_irq_i),
    .ext_irq_i     (ext_irq_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .illegal_o     (illegal_o),
    .irq_req_o     (irq_req_o),
    .irq_cause_o   (irq_cause_o),
    .irq_pc_o      (irq_pc_o)
  );

  always #20 clk_i = ~clk_i;   // 40 ns period

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("run stopped at the cycle limit of %0d", TIMEOUT_CYC);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);   // xorshift32
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic compare_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("ERROR %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  function automatic logic [31:0] mip_model();
    return {20'b0, m_lines[2], 3'b0, m_lines[1], 3'b0, m_lines[0], 3'b0};   // bits 11, 7, 3
  endfunction

  // {known, read-only}
  function automatic logic [1:0] addr_class(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
      `CSR_ADDR_MHARTID, `CSR_ADDR_MISA, `CSR_ADDR_MIP:       return 2'b11;
      `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
      `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE:   return 2'b10;
      default:                                                return 2'b00;
    endcase
  endfunction

  function automatic logic [31:0] csr_value_of(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MIMPID:   return 32'h0000_0001;
      `CSR_ADDR_MISA:     return 32'h4000_0100;   // rv32i
      `CSR_ADDR_MIP:      return mip_model();
      `CSR_ADDR_MSTATUS:  return m_mstatus;
      `CSR_ADDR_MIE:      return m_mie;
      `CSR_ADDR_MTVEC:    return m_mtvec;
      `CSR_ADDR_MSCRATCH: return m_mscratch;
      `CSR_ADDR_MEPC:     return m_mepc;
      `CSR_ADDR_MCAUSE:   return m_mcause;
      default:            return 32'h0;
    endcase
  endfunction

  // only implemented fields keep the written value
  task automatic apply_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      `CSR_ADDR_MSTATUS:  m_mstatus = val & 32'h0000_0088;   // mpie, mie
      `CSR_ADDR_MIE:      m_mie     = val & 32'h0000_0888;
      `CSR_ADDR_MTVEC:    m_mtvec   = val & 32'hFFFF_FFFC;   // direct mode
      `CSR_ADDR_MEPC:     m_mepc    = val & 32'hFFFF_FFFC;
      `CSR_ADDR_MCAUSE:   m_mcause  = val;
      `CSR_ADDR_MSCRATCH: begin
        m_mscratch  = val;
        scratch_def = 1'b1;
      end
      default: ;
    endcase
  endtask

  // drives one strobe and queues the response the model predicts
  task automatic send_request(input string name, input logic [2:0] f3,
                              input logic [11:0] addr, input logic [31:0] src);
    logic [31:0] operand;
    logic [31:0] old_v;
    logic [31:0] new_v;
    logic [1:0]  cls;
    bit          zero;
    bit          wr;
    bit          ill;
    operand = f3[2] ? {27'b0, src[4:0]} : src;   // immediate forms zero-extend
    zero    = (operand == 32'h0);
    cls     = addr_class(addr);
    old_v   = csr_value_of(addr);
    case (f3[1:0])
      2'b01:   new_v = operand;
      2'b10:   new_v = old_v | operand;
      2'b11:   new_v = old_v & ~operand;
      default: new_v = old_v;
    endcase
    wr  = (f3[1:0] != 2'b00) && !(zero && f3[1]);   // set/clear with zero only reads
    ill = !cls[1] || (f3[1:0] == 2'b00) || (wr && cls[0]);
    exp_name_q.push_back(name);
    exp_data_q.push_back(ill ? 32'h0 : old_v);
    exp_ill_q.push_back(ill);
    exp_chk_q.push_back(ill || !((addr == `CSR_ADDR_MSCRATCH) && !scratch_def));
    exp_cyc_q.push_back(cyc);
    if (!ill && wr) begin
      apply_write(addr, new_v);
    end
    csr_valid_i   = 1'b1;
    funct3_i      = f3;
    csr_addr_i    = addr;
    rs1_data_i    = src;
    uimm_i        = src[4:0];
    rs1_is_zero_i = zero;
    @(negedge clk_i);
    csr_valid_i   = 1'b0;
  endtask

  task automatic read_csr(input string name, input logic [11:0] addr);
    send_request(name, 3'd2, addr, 32'h0);   // csrrs x0
  endtask

  task automatic wait_responses();
    while (exp_data_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic pop_expected();
    void'(exp_name_q.pop_front());
    void'(exp_data_q.pop_front());
    void'(exp_ill_q.pop_front());
    void'(exp_chk_q.pop_front());
    void'(exp_cyc_q.pop_front());
  endtask

  task automatic check_irq_outputs(input string name);
    logic [31:0] pend;
    logic [31:0] cause;
    pend = mip_model() & m_mie;
    if (!m_mstatus[3]) pend = 32'h0;   // global enable
    if (pend[11])     cause = 32'h8000_000B;
    else if (pend[3]) cause = 32'h8000_0003;
    else              cause = 32'h8000_0007;
    compare_word(name, "irq_req_o", {31'b0, pend != 32'h0}, irq_req_o);
    if (pend != 32'h0) compare_word(name, "irq_cause_o", cause, irq_cause_o);
    compare_word(name, "irq_pc_o", m_mtvec, irq_pc_o);
  endtask

  //////////////////////////////
  // response monitor
  //////////////////////////////
  always @(negedge clk_i) begin
    if (rdata_valid_o === 1'b1) begin
      assert (exp_data_q.size() != 0) else begin
        err_cnt++;
        $display("response came with no request outstanding");
      end
      if (exp_data_q.size() != 0) begin
        compare_word(exp_name_q[0], "latency", 32'd2, cyc - exp_cyc_q[0]);
        if (exp_chk_q[0]) compare_word(exp_name_q[0], "rdata_o", exp_data_q[0], rdata_o);
        compare_word(exp_name_q[0], "illegal_o", {31'b0, exp_ill_q[0]}, {31'b0, illegal_o});
        pop_expected();
      end
    end else if (exp_data_q.size() != 0) begin
      assert (cyc - exp_cyc_q[0] <= 2) else begin
        err_cnt++;
        $display("no response for %s within 2 cycles", exp_name_q[0]);
        pop_expected();
      end
    end
  end

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_values_test();
    compare_word("reset", "irq_req_o", 32'h0, {31'b0, irq_req_o});
    compare_word("reset", "illegal_o", 32'h0, {31'b0, illegal_o});
    read_csr("reset mvendorid", `CSR_ADDR_MVENDORID);
    read_csr("reset marchid", `CSR_ADDR_MARCHID);
    read_csr("reset mimpid", `CSR_ADDR_MIMPID);
    read_csr("reset mhartid", `CSR_ADDR_MHARTID);
    read_csr("reset misa", `CSR_ADDR_MISA);
    read_csr("reset mtvec", `CSR_ADDR_MTVEC);
    read_csr("reset mstatus", `CSR_ADDR_MSTATUS);
    read_csr("reset mie", `CSR_ADDR_MIE);
    wait_responses();
  endtask

  task automatic rmw_test();
    logic [11:0] addr;
    logic [2:0]  f3;
    logic [31:0] src;
    int          k;
    for (int r = 0; r < 3; r++) begin
      addr = (r == 0) ? `CSR_ADDR_MSCRATCH : (r == 1) ? `CSR_ADDR_MIE : `CSR_ADDR_MSTATUS;
      for (int i = 0; i < 12; i++) begin
        k   = i % 6;
        f3  = (k < 3) ? k + 1 : k + 2;   // 1,2,3,5,6,7
        src = (i >= 6 && f3[1]) ? 32'h0 : next_rand();   // second pass, zero set/clear
        send_request($sformatf("rmw %h f3=%0d", addr, f3), f3, addr, src);
        read_csr($sformatf("rmw %h readback", addr), addr);   // back to back
      end
      wait_responses();
    end
  endtask

  task automatic illegal_access_test();
    send_request("illegal unknown addr", 3'd1, 12'h7C0, next_rand());
    send_request("illegal funct3 0", 3'd0, `CSR_ADDR_MSCRATCH, next_rand());
    send_request("illegal funct3 4", 3'd4, `CSR_ADDR_MSCRATCH, next_rand());
    send_request("illegal write misa", 3'd1, `CSR_ADDR_MISA, next_rand());
    send_request("illegal write mhartid", 3'd1, `CSR_ADDR_MHARTID, next_rand());
    send_request("illegal set mip", 3'd6, `CSR_ADDR_MIP, 32'h1F);
    send_request("legal read misa", 3'd2, `CSR_ADDR_MISA, 32'h0);
    send_request("legal clear mip", 3'd7, `CSR_ADDR_MIP, 32'h0);
    read_csr("illegal no change mscratch", `CSR_ADDR_MSCRATCH);
    read_csr("illegal no change mstatus", `CSR_ADDR_MSTATUS);
    wait_responses();
  endtask

  task automatic irq_arbitration_test();
    logic [2:0] lines;
    send_request("irq mtvec", 3'd1, `CSR_ADDR_MTVEC, next_rand());
    wait_responses();
    for (int i = 0; i < 16; i++) begin
      send_request("irq mie", 3'd1, `CSR_ADDR_MIE, next_rand());
      send_request("irq mstatus", 3'd1, `CSR_ADDR_MSTATUS, next_rand());
      wait_responses();
      lines       = i[2:0];   // every combination twice
      m_lines     = lines;
      sw_irq_i    = lines[0];
      timer_irq_i = lines[1];
      ext_irq_i   = lines[2];
      @(negedge clk_i);   // sampled into mip
      @(negedge clk_i);   // arbiter output
      check_irq_outputs($sformatf("irq lines %b", lines));
      read_csr("irq mip", `CSR_ADDR_MIP);
      wait_responses();
    end
  endtask

  task automatic trap_return_test();
    logic [31:0] pc;
    send_request("trap mie", 3'd1, `CSR_ADDR_MIE, 32'h0000_0888);
    send_request("trap mstatus", 3'd1, `CSR_ADDR_MSTATUS, 32'h0000_0008);
    wait_responses();
    m_lines     = 3'b101;   // ext beats sw
    sw_irq_i    = 1'b1;
    timer_irq_i = 1'b0;
    ext_irq_i   = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_irq_outputs("trap before");
    pc        = next_rand();
    trap_i    = 1'b1;
    trap_pc_i = pc;
    m_mepc    = pc & 32'hFFFF_FFFC;
    m_mcause  = 32'h8000_000B;   // cause of the pending ext request
    m_mstatus = m_mstatus[3] ? 32'h0000_0080 : 32'h0;   // mpie <= mie, mie cleared
    @(negedge clk_i);
    trap_i = 1'b0;
    compare_word("trap", "irq_req_o one cycle later", 32'h1, {31'b0, irq_req_o});
    @(negedge clk_i);
    check_irq_outputs("trap after");
    read_csr("trap mstatus", `CSR_ADDR_MSTATUS);
    read_csr("trap mepc", `CSR_ADDR_MEPC);
    read_csr("trap mcause", `CSR_ADDR_MCAUSE);
    wait_responses();
    mret_i    = 1'b1;
    m_mstatus = (m_mstatus[7] ? 32'h0000_0008 : 32'h0) | 32'h0000_0080;
    @(negedge clk_i);
    mret_i = 1'b0;
    @(negedge clk_i);
    check_irq_outputs("mret");
    read_csr("mret mstatus", `CSR_ADDR_MSTATUS);
    wait_responses();
    m_lines   = 3'b000;
    sw_irq_i  = 1'b0;
    ext_irq_i = 1'b0;
    @(negedge clk_i);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    rng_state     = 32'h18d9_e0d5;
    rstn_i        = 1'b0;
    csr_valid_i   = 1'b0;
    funct3_i      = 3'd0;
    csr_addr_i    = 12'h0;
    rs1_data_i    = 32'h0;
    uimm_i        = 5'd0;
    rs1_is_zero_i = 1'b0;
    trap_i        = 1'b0;
    trap_pc_i     = 32'h0;
    mret_i        = 1'b0;
    sw_irq_i      = 1'b0;
    timer_irq_i   = 1'b0;
    ext_irq_i     = 1'b0;
    m_mstatus     = 32'h0;
    m_mie         = 32'h0;
    m_mtvec       = 32'h0000_0100;   // trap base after reset
    m_mscratch    = 32'h0;
    m_mepc        = 32'h0;
    m_mcause      = 32'h0;
    m_lines       = 3'b000;
    scratch_def   = 1'b0;
    repeat (10) @(negedge clk_i);
    rstn_i = 1'b1;

    reset_values_test();
    rmw_test();
    illegal_access_test();
    irq_arbitration_test();
    trap_return_test();
    repeat (4) @(negedge clk_i);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
